// ==== src/afu_csr_regs.sv ====
`timescale 1ns/1ps
`include "mmio_params.svh"

module afu_csr_regs (
   input  logic                      clk,
   input  logic                      rst,
   cfg_req_if.afu                    req,
   output logic                      rspvalid,
   output ccip_cfg_pkg::mmio_tid_t   rsptid,
   output ccip_cfg_pkg::mmio_data_t  rspdata
);
   import ccip_cfg_pkg::*;

   localparam int WORDS = 1 << `CSR_WORDS_LOG2;
   localparam int DW_W  = `MMIO_DATA_W / 2;

   logic [DW_W-1:0]            csr [WORDS];
   logic [`CSR_WORDS_LOG2-1:0] idx;
   logic [`CSR_WORDS_LOG2-1:0] idx_even;
   logic [`CSR_WORDS_LOG2-1:0] idx_odd;

   // Low index bits pick the register
   assign idx      = req.hdr.index[`CSR_WORDS_LOG2-1:0];
   assign idx_even = {idx[`CSR_WORDS_LOG2-1:1], 1'b0};
   assign idx_odd  = {idx[`CSR_WORDS_LOG2-1:1], 1'b1};

   assign req.pop = req.wrvalid || req.rdvalid;   // Always ready

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < WORDS; i++) begin
            csr[i] <= '0;
         end
      end else if (req.wrvalid) begin
         if (req.hdr.len == LEN_ONE_DW) begin
            csr[idx] <= req.data[DW_W-1:0];
         end else begin
            // Pair write
            csr[idx_even] <= req.data[DW_W-1:0];
            csr[idx_odd]  <= req.data[`MMIO_DATA_W-1:DW_W];
         end
      end
   end

   // One-cycle response pulse per read
   always_ff @(posedge clk) begin
      if (rst) begin
         rspvalid <= 1'b0;
      end else begin
         rspvalid <= req.rdvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (req.rdvalid) begin
         rsptid  <= req.hdr.tid;
         rspdata <= {csr[idx_odd], csr[idx_even]};   // Odd word in the high half
      end
   end

   // The bridge presents one request type at a time
   a_one_kind: assert property (@(posedge clk) disable iff (rst)
                                !(req.wrvalid && req.rdvalid))
      else $error("afu_csr_regs: write and read valid together");

endmodule

// ==== src/ccip_cfg_pkg.sv ====
`include "mmio_params.svh"

package ccip_cfg_pkg;

   typedef logic [`MMIO_INDEX_W-1:0] mmio_index_t;
   typedef logic [`MMIO_TID_W-1:0]   mmio_tid_t;
   typedef logic [`MMIO_DATA_W-1:0]  mmio_data_t;

   // Length code of a request
   typedef logic [1:0] mmio_len_t;

   localparam mmio_len_t LEN_ONE_DW = 2'd0;   // 32-bit access
   localparam mmio_len_t LEN_TWO_DW = 2'd1;   // 64-bit access

   // Configuration header, 26 bits
   typedef struct packed {
      mmio_index_t index;
      mmio_len_t   len;
      logic        poison;   // Never set by this bridge
      mmio_tid_t   tid;      // Zero on writes
   } cfg_hdr_t;

endpackage

// ==== src/cfg_req_if.sv ====
`timescale 1ns/1ps

interface cfg_req_if;
   import ccip_cfg_pkg::*;

   cfg_hdr_t   hdr;       // Header of the head request
   logic       wrvalid;   // Head is a write
   logic       rdvalid;   // Head is a read
   mmio_data_t data;      // Write data, zero for reads
   logic       pop;       // Consumes the head in this cycle

   modport bridge (
      output hdr,
      output wrvalid,
      output rdvalid,
      output data,
      input  pop
   );

   modport afu (
      input  hdr,
      input  wrvalid,
      input  rdvalid,
      input  data,
      output pop
   );

endinterface

// ==== src/mmio_block.sv ====
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmio_block (
   input  logic                       clk,
   input  logic                       rst,
   // Host commands
   input  logic                       cmd_valid,
   input  logic                       cmd_write,
   input  logic                       cmd_wide,
   input  mmio_host_pkg::host_addr_t  cmd_addr,
   input  ccip_cfg_pkg::mmio_data_t   cmd_data,
   output logic                       cmd_ready,
   // Host completions
   output logic                       cpl_valid,
   output mmio_host_pkg::host_addr_t  cpl_addr,
   output ccip_cfg_pkg::mmio_data_t   cpl_data,
   // Accelerator request channel
   cfg_req_if.bridge                  req,
   // Accelerator read responses
   input  logic                       rspvalid,
   input  ccip_cfg_pkg::mmio_tid_t    rsptid,
   input  ccip_cfg_pkg::mmio_data_t   rspdata
);
   import ccip_cfg_pkg::*;

   localparam int HDR_W     = $bits(cfg_hdr_t);
   localparam int REQ_W     = 2 + HDR_W + `MMIO_DATA_W;   // {wr, rd, hdr, data}
   localparam int RSP_W     = `MMIO_TID_W + `MMIO_DATA_W;  // {tid, data}
   localparam int REQ_LIMIT = (1 << `REQ_FIFO_LOG2) - 2;

   cfg_hdr_t                  cmd_hdr;
   mmio_data_t                cmd_wdata;
   mmio_tid_t                 tid_cnt;
   mmio_index_t               id_table [1 << `MMIO_TID_W];

   logic [REQ_W-1:0]          req_din;
   logic [REQ_W-1:0]          req_dout;
   logic                      req_empty;
   logic [`REQ_FIFO_LOG2:0]   req_count;
   logic                      head_wr;
   logic                      head_rd;

   logic [RSP_W-1:0]          rsp_din;
   logic [RSP_W-1:0]          rsp_dout;
   logic                      rsp_empty;
   mmio_tid_t                 head_tid;

   // Command to header
   always_comb begin
      cmd_hdr.index  = cmd_addr[`MMIO_ADDR_W-1:2];
      cmd_hdr.len    = (cmd_write && !cmd_wide) ? LEN_ONE_DW : LEN_TWO_DW;
      cmd_hdr.poison = 1'b0;
      cmd_hdr.tid    = cmd_write ? '0 : tid_cnt;
      if (!cmd_write) begin
         cmd_wdata = '0;
      end else if (cmd_wide) begin
         cmd_wdata = cmd_data;
      end else begin
         cmd_wdata = {{(`MMIO_DATA_W / 2){1'b0}}, cmd_data[`MMIO_DATA_W/2-1:0]};
      end
   end

   assign req_din   = {cmd_write, !cmd_write, cmd_hdr, cmd_wdata};
   assign cmd_ready = (req_count < (`REQ_FIFO_LOG2 + 1)'(REQ_LIMIT));

   // Tid counter wraps at 512
   always_ff @(posedge clk) begin
      if (rst) begin
         tid_cnt <= '0;
      end else if (cmd_valid && !cmd_write) begin
         tid_cnt <= tid_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid && !cmd_write) begin
         id_table[tid_cnt] <= cmd_hdr.index;   // Index owned by this id
      end
   end

   stage_fifo #(
      .DATA_WIDTH (REQ_W),
      .DEPTH_LOG2 (`REQ_FIFO_LOG2)
   ) u_req_fifo (
      .clk   (clk),
      .rst   (rst),
      .wr_en (cmd_valid),
      .din   (req_din),
      .rd_en (req.pop),
      .dout  (req_dout),
      .empty (req_empty),
      .count (req_count)
   );

   // Head request onto the channel
   assign head_wr     = req_dout[REQ_W-1];
   assign head_rd     = req_dout[REQ_W-2];
   assign req.hdr     = req_dout[`MMIO_DATA_W +: HDR_W];
   assign req.data    = req_dout[`MMIO_DATA_W-1:0];
   assign req.wrvalid = head_wr && !req_empty;
   assign req.rdvalid = head_rd && !req_empty;

   assign rsp_din = {rsptid, rspdata};

   stage_fifo #(
      .DATA_WIDTH (RSP_W),
      .DEPTH_LOG2 (`RSP_FIFO_LOG2)
   ) u_rsp_fifo (
      .clk   (clk),
      .rst   (rst),
      .wr_en (rspvalid),
      .din   (rsp_din),
      .rd_en (!rsp_empty),   // Drain one entry per cycle
      .dout  (rsp_dout),
      .empty (rsp_empty),
      .count ()
   );

   assign head_tid = rsp_dout[RSP_W-1 -: `MMIO_TID_W];

   // Completion drain
   always_ff @(posedge clk) begin
      if (rst) begin
         cpl_valid <= 1'b0;
      end else begin
         cpl_valid <= !rsp_empty;
      end
   end

   always_ff @(posedge clk) begin
      cpl_addr <= {id_table[head_tid], 2'b00};   // Dword index back to bytes
      cpl_data <= rsp_dout[`MMIO_DATA_W-1:0];
   end

   // Host may only issue while ready
   a_cmd_ready: assert property (@(posedge clk) disable iff (rst) cmd_valid |-> cmd_ready)
      else $error("mmio_block: command issued while not ready");

endmodule

// ==== src/mmio_host_pkg.sv ====
`include "mmio_params.svh"

package mmio_host_pkg;

   // Byte address on the host command and completion ports
   typedef logic [`MMIO_ADDR_W-1:0] host_addr_t;

endpackage

// ==== src/mmio_params.svh ====
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Configuration channel widths
`define MMIO_DATA_W   64
`define MMIO_INDEX_W  14   // Dword index
`define MMIO_TID_W    9

// Host side byte address
`define MMIO_ADDR_W   16

// Staging FIFO depths as powers of two
`define REQ_FIFO_LOG2 4
`define RSP_FIFO_LOG2 4

// Accelerator register bank, 256 dwords
`define CSR_WORDS_LOG2 8

`endif

// ==== src/mmio_top.sv ====
`timescale 1ns/1ps

module mmio_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cmd_valid,
   input  logic                       cmd_write,
   input  logic                       cmd_wide,
   input  mmio_host_pkg::host_addr_t  cmd_addr,
   input  ccip_cfg_pkg::mmio_data_t   cmd_data,
   output logic                       cmd_ready,
   output logic                       cpl_valid,
   output mmio_host_pkg::host_addr_t  cpl_addr,
   output ccip_cfg_pkg::mmio_data_t   cpl_data
);
   import ccip_cfg_pkg::*;

   logic       rspvalid;
   mmio_tid_t  rsptid;
   mmio_data_t rspdata;

   cfg_req_if req_ch ();   // Request channel to the register bank

   mmio_block u_bridge (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_wide  (cmd_wide),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .cmd_ready (cmd_ready),
      .cpl_valid (cpl_valid),
      .cpl_addr  (cpl_addr),
      .cpl_data  (cpl_data),
      .req       (req_ch.bridge),
      .rspvalid  (rspvalid),
      .rsptid    (rsptid),
      .rspdata   (rspdata)
   );

   afu_csr_regs u_csr (
      .clk      (clk),
      .rst      (rst),
      .req      (req_ch.afu),
      .rspvalid (rspvalid),
      .rsptid   (rsptid),
      .rspdata  (rspdata)
   );

endmodule

// ==== src/stage_fifo.sv ====
`timescale 1ns/1ps

module stage_fifo #(
   parameter int DATA_WIDTH = 32,
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wr_en,
   input  logic [DATA_WIDTH-1:0] din,
   input  logic                  rd_en,
   output logic [DATA_WIDTH-1:0] dout,
   output logic                  empty,
   output logic [DEPTH_LOG2:0]   count
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [DATA_WIDTH-1:0] mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic                  full;

   assign dout  = mem[rd_ptr];   // Head is visible without a read
   assign empty = (count == '0);
   assign full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous read and write keeps the count
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Producer must respect its own back-pressure
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
      else $error("stage_fifo: write while full");

   // Consumer must only pop a valid head
   a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
      else $error("stage_fifo: read while empty");

endmodule

// ==== tb.f ====
+incdir+src
src/ccip_cfg_pkg.sv
src/mmio_host_pkg.sv
src/cfg_req_if.sv
src/stage_fifo.sv
src/mmio_block.sv
src/afu_csr_regs.sv
src/mmio_top.sv
tests/mmio_tb.sv

// ==== tests/mmio_tb.sv ====
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmio_tb;
   import ccip_cfg_pkg::*;
   import mmio_host_pkg::*;

   localparam int N_ZERO      = 8;     // Reads before any write
   localparam int N_PAIR      = 6;     // Write and read groups per width
   localparam int N_BURST     = 600;   // Enough reads to wrap the tid
   localparam int N_MIXED     = 1500;
   localparam int N_CMDS      = N_ZERO + 5 * N_PAIR + N_BURST + N_MIXED;
   localparam int CYCLE_LIMIT = 10 * N_CMDS + 200;
   localparam int DW_W        = `MMIO_DATA_W / 2;

   logic       clk;
   logic       rst;
   logic       cmd_valid;
   logic       cmd_write;
   logic       cmd_wide;
   host_addr_t cmd_addr;
   mmio_data_t cmd_data;
   logic       cmd_ready;
   logic       cpl_valid;
   host_addr_t cpl_addr;
   mmio_data_t cpl_data;

   logic [DW_W-1:0] model [1 << `CSR_WORDS_LOG2];   // Register bank model
   host_addr_t      exp_addr_q [$];
   mmio_data_t      exp_data_q [$];
   int              cycle_cnt;

   mmio_top mmio_top_inst (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_wide  (cmd_wide),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .cmd_ready (cmd_ready),
      .cpl_valid (cpl_valid),
      .cpl_addr  (cpl_addr),
      .cpl_data  (cpl_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_addr(input host_addr_t exp, input host_addr_t got);
      if (got !== exp) begin
         $display("[ERROR] %0t cpl_addr expected %h got %h", $time, exp, got);
         $display("Regression failed");
         $fatal(1, "completion address mismatch");
      end
   endtask

   task automatic check_data(input mmio_data_t exp, input mmio_data_t got);
      if (got !== exp) begin
         $display("[ERROR] %0t cpl_data expected %h got %h", $time, exp, got);
         $display("Regression failed");
         $fatal(1, "completion data mismatch");
      end
   endtask

   // Issue one command at the drive point and update the model
   task automatic issue_cmd(input logic write, input logic wide, input host_addr_t addr,
                            input mmio_data_t data);
      int idx;
      int even;
      while (!cmd_ready) begin
         @(posedge clk);
         #2;
      end
      cmd_valid = 1'b1;
      cmd_write = write;
      cmd_wide  = wide;
      cmd_addr  = addr;
      cmd_data  = data;
      idx  = addr[`CSR_WORDS_LOG2+1:2];
      even = idx & ~1;
      if (write && !wide) begin
         model[idx] = data[DW_W-1:0];
      end else if (write) begin
         model[even]     = data[DW_W-1:0];
         model[even + 1] = data[`MMIO_DATA_W-1:DW_W];
      end else begin
         exp_addr_q.push_back({addr[`MMIO_ADDR_W-1:2], 2'b00});   // Low bits dropped
         exp_data_q.push_back({model[even + 1], model[even]});
      end
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
   endtask

   function automatic mmio_data_t rand_data();
      return {$urandom(), $urandom()};
   endfunction

   // Completion monitor samples mid-cycle
   initial begin
      wait (rst === 1'b0);
      forever begin
         @(negedge clk);
         if (cpl_valid) begin
            if (exp_addr_q.size() == 0) begin
               $display("Completion at %0t with no read outstanding", $time);
               $display("Regression failed");
               $fatal(1, "unexpected completion");
            end else begin
               check_addr(exp_addr_q.pop_front(), cpl_addr);
               check_data(exp_data_q.pop_front(), cpl_data);
            end
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, %0d reads still outstanding",
               cycle_cnt, exp_addr_q.size());
      $display("Regression failed");
      $fatal(1, "timeout");
   end

   initial begin
      host_addr_t addr;
      int         kind;
      void'($urandom(53));
      cmd_valid    = 1'b0;
      cmd_write    = 1'b0;
      cmd_wide     = 1'b0;
      cmd_addr     = '0;
      cmd_data     = '0;
      for (int i = 0; i < (1 << `CSR_WORDS_LOG2); i++) begin
         model[i] = '0;
      end
      rst = 1'b1;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      repeat (10) @(posedge clk);   // Quiet gap before the first read
      #2;

      // Never-written registers read as zero
      for (int i = 0; i < N_ZERO; i++) begin
         issue_cmd(1'b0, 1'b0, host_addr_t'($urandom()), '0);
      end

      // Narrow write into a filled pair, then read back the pair
      for (int i = 0; i < N_PAIR; i++) begin
         addr = host_addr_t'($urandom());
         issue_cmd(1'b1, 1'b1, addr, rand_data());   // Both dwords nonzero first
         issue_cmd(1'b1, 1'b0, addr, rand_data());
         issue_cmd(1'b0, 1'b0, {addr[`MMIO_ADDR_W-1:3], 3'b000}, '0);
      end
      // Wide write and read back
      for (int i = 0; i < N_PAIR; i++) begin
         addr = host_addr_t'($urandom());
         issue_cmd(1'b1, 1'b1, addr, rand_data());
         issue_cmd(1'b0, 1'b0, addr, '0);
      end

      // Back-to-back reads across tid wraparound
      for (int i = 0; i < N_BURST; i++) begin
         issue_cmd(1'b0, 1'b0, host_addr_t'($urandom()), '0);
      end

      // Mixed traffic with some idle cycles
      for (int i = 0; i < N_MIXED; i++) begin
         kind = $urandom_range(0, 2);
         issue_cmd(kind != 2, kind == 1, host_addr_t'($urandom()), rand_data());
         if ($urandom_range(0, 3) == 0) begin
            @(posedge clk);
            #2;
         end
      end

      while (exp_addr_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (10) @(posedge clk);   // Stray completions trip the monitor
      $display("Regression passed");
      $finish;
   end

endmodule
